// ==== verilog/uart_csr_pkg.sv ====
// UART console package with CSR addresses, access types and the push word layout.
`default_nettype none

package uart_csr_pkg;

  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;

  // Custom read/write CSR range.
  localparam csr_addr_t fifo_word_csr_addr   = 12'h800;
  localparam csr_addr_t fifo_byte_csr_addr   = 12'h801;
  localparam csr_addr_t fifo_status_csr_addr = 12'h802;

  // Encoded as the funct3 field of the CSR instructions, so bit 2 marks the
  // immediate forms.
  typedef enum logic [2:0] {
    csr_op_rw  = 3'b001,
    csr_op_rs  = 3'b010,
    csr_op_rc  = 3'b011,
    csr_op_rwi = 3'b101,
    csr_op_rsi = 3'b110,
    csr_op_rci = 3'b111
  } csr_op_e;

  typedef enum logic [1:0] {
    target_none   = 2'd0,
    target_word   = 2'd1,
    target_byte   = 2'd2,
    target_status = 2'd3
  } csr_target_e;

  // The execute stage writes a whole word, the queue stores it byte by byte.
  // Byte 0 is the least significant byte and leaves the line first.
  typedef union packed {
    word_t           word;
    logic [3:0][7:0] bytes;
  } push_word_u;

  // Status CSR layout. The level field starts at bit 0 and is
  // fifo_depth_log2 + 1 bits wide.
  localparam int status_level_lsb    = 0;
  localparam int status_busy_bit     = 16;
  localparam int status_overflow_bit = 17;

endpackage

`default_nettype wire

// ==== verilog/csr_access_if.sv ====
// CSR access interface carrying one decoded access from decode to execute.
`default_nettype none

interface csr_access_if
  import uart_csr_pkg::*;
();
  logic        valid;
  csr_target_e target;
  csr_op_e     op;
  word_t       operand;
  logic        write_en;
  word_t       read_data;

  modport decode (
    output valid,
    output target,
    output op,
    output operand,
    output write_en
  );

  modport execute (
    input  valid,
    input  target,
    input  op,
    input  operand,
    input  write_en,
    output read_data
  );
endinterface

`default_nettype wire

// ==== verilog/csr_decode.sv ====
// CSR decode maps the core's CSR port onto a target, an operation and an operand.
`default_nettype none

module csr_decode
  import uart_csr_pkg::*;
(
  input  logic         csr_enable,
  input  csr_addr_t    csr_addr,
  input  csr_op_e      csr_op,
  input  logic [4:0]   rs1_zimm,
  input  word_t        rs1_data,
  csr_access_if.decode acc
);

  logic is_imm;
  logic is_rw;

  always_comb begin
    is_imm = csr_op inside {csr_op_rwi, csr_op_rsi, csr_op_rci};
    is_rw  = csr_op inside {csr_op_rw, csr_op_rwi};
  end

  always_comb begin
    case (csr_addr)
      fifo_word_csr_addr:   acc.target = target_word;
      fifo_byte_csr_addr:   acc.target = target_byte;
      fifo_status_csr_addr: acc.target = target_status;
      default:              acc.target = target_none;
    endcase
  end

  always_comb begin
    acc.valid = csr_enable;
    acc.op    = csr_op;

    if (is_imm) begin
      acc.operand = {27'b0, rs1_zimm};
    end else begin
      acc.operand = rs1_data;
    end

    // Set and clear with x0 or a zero immediate only read the register.
    acc.write_en = csr_enable && (is_rw || (rs1_zimm != 5'd0));
  end

endmodule

`default_nettype wire

// ==== verilog/csr_execute.sv ====
// CSR execute holds the console registers, applies read-modify-write and issues pushes.
`default_nettype none

module csr_execute
  import uart_csr_pkg::*;
#(
  parameter int fifo_depth_log2 = 5
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  csr_access_if.execute              acc,
  output logic                       push_valid,
  output logic                       push_is_word,
  output push_word_u                 push_data,
  input  logic [fifo_depth_log2-1:0] level,
  input  logic                       full,
  input  logic                       overflow_seen,
  input  logic                       busy,
  output logic                       overflow_clear
);

  word_t      word_reg;
  logic [7:0] byte_reg;
  word_t      status_value;
  word_t      old_value;
  word_t      new_value;
  logic       write;
  logic       push_target;

  // A full queue has wrapped the low level bits to zero, so the full flag
  // is the top bit of the fill count.
  always_comb begin
    status_value = '0;
    status_value[status_level_lsb +: fifo_depth_log2 + 1] = {full, level};
    status_value[status_busy_bit]     = busy;
    status_value[status_overflow_bit] = overflow_seen;
  end

  always_comb begin
    case (acc.target)
      target_word:   old_value = word_reg;
      target_byte:   old_value = {24'b0, byte_reg};
      target_status: old_value = status_value;
      default:       old_value = '0;
    endcase

    case (acc.op)
      csr_op_rw, csr_op_rwi: new_value = acc.operand;
      csr_op_rs, csr_op_rsi: new_value = old_value | acc.operand;
      csr_op_rc, csr_op_rci: new_value = old_value & ~acc.operand;
      default:               new_value = old_value;
    endcase

    acc.read_data = acc.valid ? old_value : '0;
  end

  assign write       = acc.valid && acc.write_en;
  assign push_target = (acc.target == target_word) || (acc.target == target_byte);

  // Only the overflow bit of the status CSR is writable.
  assign overflow_clear = write && (acc.target == target_status) &&
                          !new_value[status_overflow_bit];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      word_reg   <= '0;
      byte_reg   <= '0;
      push_valid <= 1'b0;
    end else begin
      push_valid <= write && push_target;
      if (write && (acc.target == target_word)) begin
        word_reg <= new_value;
      end
      if (write && (acc.target == target_byte)) begin
        byte_reg <= new_value[7:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (write && push_target) begin
      push_is_word   <= (acc.target == target_word);
      push_data.word <= new_value;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tx_fifo.sv ====
// Transmit byte queue that takes word or byte pushes and feeds the serializer.
`default_nettype none

module tx_fifo
  import uart_csr_pkg::*;
#(
  parameter int fifo_depth_log2 = 5
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       push_valid,
  input  logic                       push_is_word,
  input  push_word_u                 push_data,
  input  logic                       overflow_clear,
  input  logic                       take,
  output logic                       byte_valid,
  output logic [7:0]                 byte_data,
  output logic [fifo_depth_log2-1:0] level,
  output logic                       full,
  output logic                       overflow_seen
);

  localparam int depth = 1 << fifo_depth_log2;

  logic [7:0]                 mem [depth];
  logic [fifo_depth_log2:0]   wr_ptr;
  logic [fifo_depth_log2:0]   rd_ptr;
  logic [fifo_depth_log2:0]   count;
  logic [fifo_depth_log2-1:0] wr_idx;
  logic                       room;
  logic                       accept;

  // Pointers carry one extra wrap bit, so count reaches depth when full.
  assign count  = wr_ptr - rd_ptr;
  assign level  = count[fifo_depth_log2-1:0];
  assign full   = count[fifo_depth_log2];
  assign wr_idx = wr_ptr[fifo_depth_log2-1:0];

  assign byte_valid = (count != '0);
  assign byte_data  = mem[rd_ptr[fifo_depth_log2-1:0]];

  // A word needs four free slots or is dropped whole.
  assign room   = push_is_word ? (count <= (fifo_depth_log2 + 1)'(depth - 4)) : !full;
  assign accept = push_valid && room;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      overflow_seen <= 1'b0;
    end else begin
      if (accept) begin
        wr_ptr <= wr_ptr + (push_is_word ? (fifo_depth_log2 + 1)'(4) : (fifo_depth_log2 + 1)'(1));
      end
      if (take) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // A drop in the same cycle as a clear wins, since it is newer.
      if (push_valid && !room) begin
        overflow_seen <= 1'b1;
      end else if (overflow_clear) begin
        overflow_seen <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      for (int i = 0; i < 4; i++) begin
        if (push_is_word || (i == 0)) begin
          mem[wr_idx + fifo_depth_log2'(i)] <= push_data.bytes[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
// UART transmitter that sends 8N1 frames at a fixed number of clocks per bit.
`default_nettype none

module uart_tx #(
  parameter int clks_per_bit = 868
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       byte_valid,
  input  logic [7:0] byte_data,
  output logic       take,
  output logic       busy,
  output logic       tx
);

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_start = 2'd1;
  localparam logic [1:0] st_data  = 2'd2;
  localparam logic [1:0] st_stop  = 2'd3;

  logic [1:0]       state;
  logic [cnt_w-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;
  logic             bit_done;

  assign bit_done = (clk_cnt == cnt_w'(clks_per_bit - 1));
  assign take     = (state == st_idle) && byte_valid;
  assign busy     = (state != st_idle);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state   <= st_idle;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else begin
      clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
      case (state)
        st_idle: begin
          clk_cnt <= '0;
          if (byte_valid) begin
            state <= st_start;
            tx    <= 1'b0;
          end
        end
        st_start: begin
          if (bit_done) begin
            state   <= st_data;
            bit_idx <= '0;
            tx      <= shift[0];
          end
        end
        st_data: begin
          if (bit_done) begin
            if (bit_idx == 3'd7) begin
              state <= st_stop;
              tx    <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx      <= shift[1];
            end
          end
        end
        default: begin
          if (bit_done) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // Bit 0 of the shift register is always the bit on the line.
  always_ff @(posedge clk_i) begin
    if (take) begin
      shift <= byte_data;
    end else if ((state == st_data) && bit_done) begin
      shift <= shift >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/uart_csr_tx.sv ====
// Console output top level joining the CSR port to the UART line.
`default_nettype none

module uart_csr_tx
  import uart_csr_pkg::*;
#(
  parameter int clks_per_bit    = 868,
  parameter int fifo_depth_log2 = 5
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       csr_enable,
  input  csr_addr_t  csr_addr,
  input  csr_op_e    csr_op,
  input  logic [4:0] rs1_zimm,
  input  word_t      rs1_data,
  output word_t      csr_data_out,
  output logic       tx
);

  logic                       push_valid;
  logic                       push_is_word;
  push_word_u                 push_data;
  logic [fifo_depth_log2-1:0] level;
  logic                       full;
  logic                       overflow_seen;
  logic                       overflow_clear;
  logic                       byte_valid;
  logic [7:0]                 byte_data;
  logic                       take;
  logic                       busy;

  csr_access_if acc ();

  assign csr_data_out = acc.read_data;

  csr_decode u_csr_decode (
    .csr_enable (csr_enable),
    .csr_addr   (csr_addr),
    .csr_op     (csr_op),
    .rs1_zimm   (rs1_zimm),
    .rs1_data   (rs1_data),
    .acc        (acc.decode)
  );

  csr_execute #(
    .fifo_depth_log2 (fifo_depth_log2)
  ) u_csr_execute (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .acc            (acc.execute),
    .push_valid     (push_valid),
    .push_is_word   (push_is_word),
    .push_data      (push_data),
    .level          (level),
    .full           (full),
    .overflow_seen  (overflow_seen),
    .busy           (busy),
    .overflow_clear (overflow_clear)
  );

  tx_fifo #(
    .fifo_depth_log2 (fifo_depth_log2)
  ) u_tx_fifo (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .push_valid     (push_valid),
    .push_is_word   (push_is_word),
    .push_data      (push_data),
    .overflow_clear (overflow_clear),
    .take           (take),
    .byte_valid     (byte_valid),
    .byte_data      (byte_data),
    .level          (level),
    .full           (full),
    .overflow_seen  (overflow_seen)
  );

  uart_tx #(
    .clks_per_bit (clks_per_bit)
  ) u_uart_tx (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .take       (take),
    .busy       (busy),
    .tx         (tx)
  );

endmodule

`default_nettype wire

// ==== bench/uart_csr_tx_tb.sv ====
// Testbench for the UART console block, driving CSR accesses and checking the serial line.
`default_nettype none

module uart_csr_tx_tb
  import uart_csr_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clks_per_bit = 8;
  localparam int fifo_depth   = 32;
  localparam int idle_gap     = 2;
  localparam word_t ovf_mask  = word_t'(1) << status_overflow_bit;

  typedef struct {
    csr_op_e    op;
    csr_addr_t  addr;
    logic [4:0] zimm;
    word_t      data;
    word_t      exp;
    bit         push;
    word_t      push_val;
    bit         drain;
  } entry_t;

  logic       clk_i = 1'b0;
  logic       reset_i;
  logic       csr_enable;
  csr_addr_t  csr_addr;
  csr_op_e    csr_op;
  logic [4:0] rs1_zimm;
  word_t      rs1_data;
  word_t      csr_data_out;
  logic       tx;

  entry_t     stim_q[$];
  logic [7:0] exp_q[$];
  bit         in_frame = 1'b0;
  word_t      rand_state;
  int         word_errors = 0;
  int         byte_errors = 0;
  int         frame_errors = 0;
  int         cycles = 0;
  int         cycle_limit = 0;

  uart_csr_tx #(
    .clks_per_bit    (clks_per_bit),
    .fifo_depth_log2 (5)
  ) u_uart_csr_tx (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .csr_enable   (csr_enable),
    .csr_addr     (csr_addr),
    .csr_op       (csr_op),
    .rs1_zimm     (rs1_zimm),
    .rs1_data     (rs1_data),
    .csr_data_out (csr_data_out),
    .tx           (tx)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if ((cycle_limit != 0) && (cycles >= cycle_limit)) begin
      $display("Timeout after %0d cycles with %0d bytes still expected on tx",
               cycles, exp_q.size());
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic word_t next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      word_errors++;
      $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      byte_errors++;
      $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_entry(input csr_op_e op, input csr_addr_t addr, input logic [4:0] zimm,
                           input word_t data, input word_t exp, input bit push,
                           input word_t push_val, input bit drain);
    entry_t e;
    e = '{op, addr, zimm, data, exp, push, push_val, drain};
    stim_q.push_back(e);
  endtask

  // Expected reads follow a local copy of the word and byte registers.
  task automatic build_stimulus();
    word_t w_reg;
    word_t d;
    word_t full_busy;
    w_reg = '0;
    full_busy = (word_t'(fifo_depth) << status_level_lsb) | (word_t'(1) << status_busy_bit);
    add_entry(csr_op_rs, fifo_status_csr_addr, 5'd0, '1, '0, 1'b0, '0, 1'b1);
    repeat (2) begin
      d = next_rand();
      add_entry(csr_op_rw, fifo_word_csr_addr, 5'd10, d, w_reg, 1'b1, d, 1'b0);
      w_reg = d;
    end
    add_entry(csr_op_rs, fifo_word_csr_addr, 5'd0, next_rand(), w_reg, 1'b0, '0, 1'b0);
    add_entry(csr_op_rsi, fifo_word_csr_addr, 5'd0, '1, w_reg, 1'b0, '0, 1'b0);
    add_entry(csr_op_rwi, fifo_byte_csr_addr, 5'h15, '1, 32'h00, 1'b1, 32'h15, 1'b0);
    add_entry(csr_op_rsi, fifo_byte_csr_addr, 5'h0a, '1, 32'h15, 1'b1, 32'h1f, 1'b0);
    add_entry(csr_op_rci, fifo_byte_csr_addr, 5'h03, '1, 32'h1f, 1'b1, 32'h1c, 1'b0);
    add_entry(csr_op_rs, fifo_byte_csr_addr, 5'd7, 32'h40, 32'h1c, 1'b1, 32'h5c, 1'b0);
    add_entry(csr_op_rc, fifo_byte_csr_addr, 5'd8, 32'h0c, 32'h5c, 1'b1, 32'h50, 1'b0);
    add_entry(csr_op_rs, fifo_byte_csr_addr, 5'd0, 32'hff, 32'h50, 1'b0, '0, 1'b0);
    add_entry(csr_op_rw, fifo_byte_csr_addr, 5'd9, 32'ha5c3_0041, 32'h50, 1'b1, 32'h41,
              1'b0);
    add_entry(csr_op_rci, fifo_byte_csr_addr, 5'd0, '1, 32'h41, 1'b0, '0, 1'b0);
    // Addresses outside the three console CSRs.
    add_entry(csr_op_rw, 12'h803, 5'd4, next_rand(), '0, 1'b0, '0, 1'b0);
    add_entry(csr_op_rsi, 12'h7c0, 5'd3, '1, '0, 1'b0, '0, 1'b0);
    d = next_rand();
    add_entry(csr_op_rc, fifo_word_csr_addr, 5'd11, d, w_reg, 1'b1, w_reg & ~d, 1'b0);
    w_reg = w_reg & ~d;
    d = next_rand();
    add_entry(csr_op_rs, fifo_word_csr_addr, 5'd12, d, w_reg, 1'b1, w_reg | d, 1'b0);
    w_reg = w_reg | d;
    // A burst that overfills the 32 byte queue from an idle start.
    add_entry(csr_op_rs, fifo_status_csr_addr, 5'd0, '1, '0, 1'b0, '0, 1'b1);
    repeat (9) begin
      d = next_rand();
      add_entry(csr_op_rw, fifo_word_csr_addr, 5'd13, d, w_reg, 1'b1, d, 1'b0);
      w_reg = d;
    end
    add_entry(csr_op_rwi, fifo_byte_csr_addr, 5'h1e, '1, 32'h41, 1'b1, 32'h1e, 1'b0);
    add_entry(csr_op_rwi, fifo_byte_csr_addr, 5'h0f, '1, 32'h1e, 1'b1, 32'h0f, 1'b0);
    // Only the first byte has left the queue, so it stays full during the first frame.
    add_entry(csr_op_rs, fifo_status_csr_addr, 5'd0, '1, full_busy | ovf_mask, 1'b0, '0,
              1'b0);
    add_entry(csr_op_rc, fifo_status_csr_addr, 5'd6, ovf_mask, full_busy | ovf_mask, 1'b0,
              '0, 1'b0);
    add_entry(csr_op_rs, fifo_status_csr_addr, 5'd0, '1, full_busy, 1'b0, '0, 1'b0);
    add_entry(csr_op_rs, fifo_word_csr_addr, 5'd0, '1, w_reg, 1'b0, '0, 1'b0);
  endtask

  // Queue occupancy excludes the byte the serializer has already taken.
  task automatic model_push(input csr_addr_t addr, input word_t val);
    int occ;
    occ = exp_q.size() - (in_frame ? 1 : 0);
    if (addr == fifo_word_csr_addr) begin
      if (occ + 4 <= fifo_depth) begin
        for (int i = 0; i < 4; i++) begin
          exp_q.push_back(val[8*i +: 8]);
        end
      end
    end else if (occ < fifo_depth) begin
      exp_q.push_back(val[7:0]);
    end
  endtask

  // The line counts as idle once nothing is expected and no frame starts for two bit times.
  task automatic wait_line_idle();
    int quiet;
    quiet = 0;
    while (quiet < 2 * clks_per_bit) begin
      @(negedge clk_i);
      if ((exp_q.size() != 0) || in_frame) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
  endtask

  task automatic apply_entry(input entry_t e);
    if (e.drain) begin
      wait_line_idle();
    end
    @(negedge clk_i);
    if (e.push) begin
      model_push(e.addr, e.push_val);
    end
    csr_enable = 1'b1;
    csr_addr   = e.addr;
    csr_op     = e.op;
    rs1_zimm   = e.zimm;
    rs1_data   = e.data;
    #5;
    check_word("csr_data_out", csr_data_out, e.exp);
    @(negedge clk_i);
    csr_enable = 1'b0;
    repeat (idle_gap) @(negedge clk_i);
  endtask

  // Samples every bit at its center, counted in falling clock edges.
  initial begin : line_monitor
    logic [7:0] got;
    wait (reset_i === 1'b0);
    forever begin
      @(negedge tx);
      in_frame = 1'b1;
      repeat (clks_per_bit / 2) @(negedge clk_i);
      if (tx !== 1'b0) begin
        frame_errors++;
        $display("Start bit on tx did not stay low at time %0t", $time);
      end
      for (int b = 0; b < 8; b++) begin
        repeat (clks_per_bit) @(negedge clk_i);
        got[b] = tx;
      end
      repeat (clks_per_bit) @(negedge clk_i);
      if (tx !== 1'b1) begin
        frame_errors++;
        $display("Stop bit on tx was low at time %0t", $time);
      end
      if (exp_q.size() == 0) begin
        frame_errors++;
        $display("Byte %h arrived on tx with no byte expected at time %0t", got, $time);
      end else begin
        check_byte("tx byte", got, exp_q.pop_front());
      end
      in_frame = 1'b0;
    end
  end

  initial begin
    reset_i    = 1'b1;
    csr_enable = 1'b0;
    csr_addr   = '0;
    csr_op     = csr_op_rs;
    rs1_zimm   = '0;
    rs1_data   = '0;
    rand_state = 32'd80;
    build_stimulus();
    cycle_limit = stim_q.size() * 40 * clks_per_bit + 2000;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    if (tx !== 1'b1) begin
      frame_errors++;
      $display("Line tx was not idle high after reset at time %0t", $time);
    end
    foreach (stim_q[i]) begin
      apply_entry(stim_q[i]);
    end
    wait_line_idle();
    $display("Errors: read data %0d, serial bytes %0d, framing %0d",
             word_errors, byte_errors, frame_errors);
    if ((word_errors + byte_errors + frame_errors) == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== uart_csr_tx.f ====
verilog/uart_csr_pkg.sv
verilog/csr_access_if.sv
verilog/csr_decode.sv
verilog/csr_execute.sv
verilog/tx_fifo.sv
verilog/uart_tx.sv
verilog/uart_csr_tx.sv
bench/uart_csr_tx_tb.sv

// ==== Makefile ====
TOP = uart_csr_tx_tb

sim:
	verilator --binary --timing -f uart_csr_tx.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

.PHONY: sim clean
